// ==== Makefile ====
# Verilator build and run of the PC/XT front end testbench

VERILATOR ?= verilator
TOP       ?= tb_pcxt_frontend
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_pcxt_frontend.sv ====
// Self-checking testbench for the PC/XT front end on CLK_50M.
// Short timing parameters: 20 ticks per second, 12-cycle LED hold.
// Checks run as assertions against reference models kept in this file.

`timescale 1ns/1ps

module tb_pcxt_frontend;

	localparam int unsigned TICKS      = 20;
	localparam int unsigned LED_ON     = 12;
	localparam int unsigned SPLASH_LEN = pcxt_pkg::SPLASH_SECONDS * TICKS;
	localparam int          PIX_COUNT  = 50;
	localparam int          MIX_CYCLES = 1200;
	// About twice the summed phase lengths
	localparam int          CYCLE_LIMIT = 4000;

	logic                              CLK_50M;
	logic                              reset;
	pcxt_pkg::osd_cfg_t                cfg;
	pcxt_pkg::pixel_t                  pix_in;
	pcxt_pkg::vga_t                    pix_out;
	pcxt_pkg::snd_in_t                 snd_in;
	logic                              snd_in_valid;
	logic                              snd_in_ready;
	logic signed [pcxt_pkg::SND_W-1:0] audio;
	logic                              audio_valid;
	logic                              audio_ready;
	logic                              activity;
	logic                              led_user;
	logic                              cpu_hold;
	logic [pcxt_pkg::AR_W-1:0]         video_arx;
	logic [pcxt_pkg::AR_W-1:0]         video_ary;

	// Reference model state
	logic                              core_rst;
	logic                              started = 1'b0;
	pcxt_pkg::vga_t                    pix_exp;
	logic                              splash_model;
	int unsigned                       splash_ticks;
	int unsigned                       led_age = LED_ON;
	logic [pcxt_pkg::SND_W-1:0]        exp_q[$];
	logic [pcxt_pkg::SND_W-1:0]        head_sample;
	logic                              head_valid = 1'b0;
	logic                              in_taken = 1'b0;
	int                                sent_cnt = 0;
	int                                recv_cnt = 0;
	int                                cycle_cnt = 0;
	logic [31:0]                       rnd;

	pcxt_frontend #(
		.TICKS_PER_SECOND(TICKS),
		.HOLD_CYCLES     (LED_ON)
	) u_pcxt_frontend (.*);

	assign core_rst = reset || cfg.reset_req;

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic mismatch_error(string name, logic [63:0] got, logic [63:0] want);
		$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, want);
		stop_with_failure();
	endtask

	task automatic abort_run(string reason);
		$display("%s", reason);
		stop_with_failure();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [pcxt_pkg::AR_W-1:0] aspect_x(logic [1:0] a);
		if (a == 2'd0) begin
			return 13'd4;
		end
		return {11'd0, a} - 13'd1;
	endfunction

	function automatic logic [pcxt_pkg::AR_W-1:0] aspect_y(logic [1:0] a);
		return (a == 2'd0) ? 13'd3 : 13'd0;
	endfunction

	function automatic pcxt_pkg::vga_t tinted_pixel(pcxt_pkg::osd_cfg_t c,
			pcxt_pkg::pixel_t p);
		pcxt_pkg::vga_t v;
		logic [5:0]     y;
		logic [5:0]     r;
		logic [5:0]     g;
		logic [5:0]     b;
		y = pcxt_pkg::RED_WEIGHT[p.r] + pcxt_pkg::GREEN_WEIGHT[p.g]
			+ pcxt_pkg::BLUE_WEIGHT[p.b];
		{r, g, b} = {p.r, p.g, p.b};
		// MDA ignores the tint
		if (c.video_mode == pcxt_pkg::VIDEO_CGA) begin
			case (c.cga_tint)
				pcxt_pkg::TINT_GREEN: {r, g, b} = {6'd0, y, 6'd0};
				pcxt_pkg::TINT_AMBER: {r, g, b} = {y, 1'b0, y[5:1], 6'd0};
				pcxt_pkg::TINT_BW:    {r, g, b} = {y, y, y};
				default:              {r, g, b} = {p.r, p.g, p.b};
			endcase
		end
		v = {{r, 2'b00}, {g, 2'b00}, {b, 2'b00}, p.hs, p.vs, p.de};
		return v;
	endfunction

	// OPL x4 plus speaker at 32768 plus Tandy x64 wrapped to 17 bits and halved
	function automatic logic [pcxt_pkg::SND_W-1:0] mixed_sample(pcxt_pkg::snd_in_t s);
		int          total;
		logic [16:0] wrapped;
		total   = int'($signed(s.opl)) * 4 + (s.speaker ? 32768 : 0) + int'(s.tandy) * 64;
		wrapped = total[16:0];
		return wrapped[16:1];
	endfunction

	// Models advance on the same edges as the DUT
	always @(posedge CLK_50M) begin
		started <= 1'b1;
		if (core_rst) begin
			pix_exp      <= '0;
			splash_model <= 1'b1;
			splash_ticks <= 0;
			led_age      <= LED_ON;
			exp_q.delete();
			head_valid   <= 1'b0;
			in_taken     <= 1'b0;
		end else begin
			pix_exp <= tinted_pixel(cfg, pix_in);
			if (splash_model) begin
				if (cfg.skip_splash || splash_ticks == SPLASH_LEN - 1) begin
					splash_model <= 1'b0;
				end
				splash_ticks <= splash_ticks + 1;
			end
			// Age since the last pulse saturates at the on-time
			if (activity) begin
				led_age <= 0;
			end else if (led_age < LED_ON) begin
				led_age <= led_age + 1;
			end
			// Drain before fill since the register empties as it refills
			in_taken <= snd_in_valid && snd_in_ready;
			if (audio_valid && audio_ready && exp_q.size() != 0) begin
				exp_q.delete(0);
				recv_cnt <= recv_cnt + 1;
			end
			if (snd_in_valid && snd_in_ready) begin
				exp_q.push_back(mixed_sample(snd_in));
				sent_cnt <= sent_cnt + 1;
			end
			head_valid  <= (exp_q.size() != 0);
			head_sample <= (exp_q.size() != 0) ? exp_q[0] : 16'd0;
		end
	end

	always @(posedge CLK_50M) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			abort_run("Timeout, the run did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	a_arx: assert property (@(posedge CLK_50M) video_arx == aspect_x(cfg.aspect))
	else mismatch_error("video_arx", 64'($sampled(video_arx)),
		64'(aspect_x($sampled(cfg.aspect))));

	a_ary: assert property (@(posedge CLK_50M) video_ary == aspect_y(cfg.aspect))
	else mismatch_error("video_ary", 64'($sampled(video_ary)),
		64'(aspect_y($sampled(cfg.aspect))));

	a_pixel: assert property (@(posedge CLK_50M) started |-> pix_out == pix_exp)
	else mismatch_error("pix_out", 64'($sampled(pix_out)), 64'($sampled(pix_exp)));

	a_hold: assert property (@(posedge CLK_50M) started |-> cpu_hold == (core_rst || splash_model))
	else mismatch_error("cpu_hold", 64'($sampled(cpu_hold)),
		64'($sampled(core_rst) || $sampled(splash_model)));

	a_led: assert property (@(posedge CLK_50M) started |-> led_user == (led_age < LED_ON))
	else mismatch_error("led_user", 64'($sampled(led_user)), 64'($sampled(led_age) < LED_ON));

	// Ready when the modelled output register is empty or draining
	a_ready: assert property (@(posedge CLK_50M) disable iff (core_rst)
		started |-> snd_in_ready == (!head_valid || audio_ready))
	else mismatch_error("snd_in_ready", 64'($sampled(snd_in_ready)),
		64'(!$sampled(head_valid) || $sampled(audio_ready)));

	// Output must be the oldest accepted sample and none may vanish
	a_audio: assert property (@(posedge CLK_50M) disable iff (core_rst)
		audio_valid |-> head_valid && audio == head_sample)
	else mismatch_error("audio", 64'($sampled(audio)), 64'($sampled(head_sample)));

	a_no_loss: assert property (@(posedge CLK_50M) disable iff (core_rst)
		head_valid |-> audio_valid)
	else abort_run("Accepted sample missing from the audio output");

	a_backpressure: assert property (@(posedge CLK_50M) disable iff (core_rst)
		audio_valid && !audio_ready |=> audio_valid && $stable(audio))
	else abort_run("Audio sample changed or dropped while audio_ready was low");

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge CLK_50M);
		#2;
	endtask

	initial begin
		rnd          = $urandom(10);
		reset        = 1'b1;
		cfg          = '0;
		pix_in       = '0;
		snd_in       = '0;
		snd_in_valid = 1'b0;
		audio_ready  = 1'b0;
		activity     = 1'b0;
		repeat (3) @(posedge CLK_50M);
		#2;
		reset = 1'b0;

		// Aspect decode
		for (int a = 0; a < 4; a++) begin
			cfg.aspect = a[1:0];
			step();
		end

		// Every CGA tint then MDA with random tints
		for (int t = 0; t < 5; t++) begin
			cfg.video_mode = (t == 4) ? pcxt_pkg::VIDEO_MDA : pcxt_pkg::VIDEO_CGA;
			repeat (PIX_COUNT) begin
				rnd          = $urandom;
				cfg.cga_tint = pcxt_pkg::tint_t'((t == 4) ? rnd[31:30] : t[1:0]);
				pix_in       = pcxt_pkg::pixel_t'(rnd[20:0]);
				step();
			end
		end
		cfg.video_mode = pcxt_pkg::VIDEO_CGA;

		// Full splash then reset request and a skipped splash
		while (cpu_hold) step();
		repeat (3) step();
		cfg.reset_req = 1'b1;
		repeat (2) step();
		cfg.reset_req   = 1'b0;
		cfg.skip_splash = 1'b1;
		while (cpu_hold) step();
		step();
		cfg.skip_splash = 1'b0;

		// Sample stream under random back-pressure
		repeat (MIX_CYCLES) begin
			rnd         = $urandom;
			audio_ready = rnd[31];
			if (!snd_in_valid || in_taken) begin
				snd_in_valid = (rnd[30:29] != 2'd0);
				snd_in       = pcxt_pkg::snd_in_t'(rnd[24:0]);
			end
			step();
		end
		snd_in_valid = 1'b0;
		audio_ready  = 1'b1;
		while (audio_valid) step();

		// Single pulse then a pulse that extends the on-time
		activity = 1'b1;
		step();
		activity = 1'b0;
		while (led_user) step();
		activity = 1'b1;
		step();
		activity = 1'b0;
		repeat (6) step();
		activity = 1'b1;
		step();
		activity = 1'b0;
		while (led_user) step();
		step();

		if (sent_cnt == 0 || sent_cnt != recv_cnt) begin
			abort_run($sformatf("Audio count mismatch, %0d sent and %0d received",
				sent_cnt, recv_cnt));
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== files.f ====
rtl/pcxt_pkg.sv
rtl/mono_tint.sv
rtl/splash_timer.sv
rtl/sound_mixer.sv
rtl/activity_led.sv
rtl/pcxt_frontend.sv
dv/tb_pcxt_frontend.sv

// ==== rtl/activity_led.sv ====
// Stretches single-cycle activity pulses to a visible LED on-time.
// HOLD_CYCLES must fit the package LED counter width.

`timescale 1ns/1ps

module activity_led #(
	parameter int unsigned HOLD_CYCLES = pcxt_pkg::LED_HOLD_CYCLES
) (
	input  logic CLK_50M,
	input  logic reset,
	input  logic activity,
	output logic led_user
);

	pcxt_pkg::led_cnt_t hold_cnt;

	// Each pulse restarts the on-time
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (activity) begin
			hold_cnt <= pcxt_pkg::led_cnt_t'(HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Lit for HOLD_CYCLES clocks after the last pulse
	assign led_user = (hold_cnt != '0);

endmodule

// ==== rtl/mono_tint.sv ====
// One-cycle video stage: CGA pixels tinted by weighted luma, MDA untouched.
// No stall path, output follows input by exactly one clock.
// Output channels are the 6-bit core value with two zero LSBs.

`timescale 1ns/1ps

module mono_tint (
	input  logic                  CLK_50M,
	input  logic                  reset,
	input  pcxt_pkg::video_mode_t video_mode,
	input  pcxt_pkg::tint_t       tint,
	input  pcxt_pkg::pixel_t      pix_in,
	output pcxt_pkg::vga_t        pix_out
);

	// One extra bit to catch a luma overflow
	logic [pcxt_pkg::COLOR_W:0]   luma_sum;
	logic [pcxt_pkg::COLOR_W-1:0] luma;
	logic [pcxt_pkg::COLOR_W-1:0] luma_half;
	logic [pcxt_pkg::COLOR_W-1:0] r_sel;
	logic [pcxt_pkg::COLOR_W-1:0] g_sel;
	logic [pcxt_pkg::COLOR_W-1:0] b_sel;

	////////////////////////////////////////////////////////////////////////////
	// Luma from the three weight tables
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		luma_sum = {1'b0, pcxt_pkg::RED_WEIGHT[pix_in.r]}
			+ {1'b0, pcxt_pkg::GREEN_WEIGHT[pix_in.g]}
			+ {1'b0, pcxt_pkg::BLUE_WEIGHT[pix_in.b]};
	end

	assign luma      = luma_sum[pcxt_pkg::COLOR_W-1:0];
	// Amber green channel at half level
	assign luma_half = luma >> 1;

	////////////////////////////////////////////////////////////////////////////
	// Channel select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Pass-through unless a CGA tint applies
		r_sel = pix_in.r;
		g_sel = pix_in.g;
		b_sel = pix_in.b;
		if (video_mode == pcxt_pkg::VIDEO_CGA) begin
			case (tint)
				pcxt_pkg::TINT_GREEN: begin
					r_sel = '0;
					g_sel = luma;
					b_sel = '0;
				end
				pcxt_pkg::TINT_AMBER: begin
					r_sel = luma;
					g_sel = luma_half;
					b_sel = '0;
				end
				pcxt_pkg::TINT_BW: begin
					r_sel = luma;
					g_sel = luma;
					b_sel = luma;
				end
				// Colour keeps the input
				default: begin
					r_sel = pix_in.r;
					g_sel = pix_in.g;
					b_sel = pix_in.b;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register, syncs travel with the colour
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			pix_out <= '0;
		end else begin
			pix_out.r  <= {r_sel, {pcxt_pkg::PAD_W{1'b0}}};
			pix_out.g  <= {g_sel, {pcxt_pkg::PAD_W{1'b0}}};
			pix_out.b  <= {b_sel, {pcxt_pkg::PAD_W{1'b0}}};
			pix_out.hs <= pix_in.hs;
			pix_out.vs <= pix_in.vs;
			pix_out.de <= pix_in.de;
		end
	end

	// Tables must keep the luma inside six bits
	a_luma_range: assert property (@(posedge CLK_50M) disable iff (reset)
		luma_sum[pcxt_pkg::COLOR_W] == 1'b0)
	else $error("luma overflow %0d", luma_sum);

endmodule

// ==== rtl/pcxt_frontend.sv ====
// Glue between the OSD option word and the board outputs of a PC/XT core.
// Single clock domain on CLK_50M. OSD reset request acts like board reset.
// Aspect outputs are combinational from the option word.

`timescale 1ns/1ps

module pcxt_frontend #(
	parameter int unsigned TICKS_PER_SECOND = pcxt_pkg::CLK_HZ,
	parameter int unsigned HOLD_CYCLES      = pcxt_pkg::LED_HOLD_CYCLES
) (
	input  logic                              CLK_50M,
	input  logic                              reset,
	input  pcxt_pkg::osd_cfg_t                cfg,

	// Video
	input  pcxt_pkg::pixel_t                  pix_in,
	output pcxt_pkg::vga_t                    pix_out,

	// Audio stream
	input  pcxt_pkg::snd_in_t                 snd_in,
	input  logic                              snd_in_valid,
	output logic                              snd_in_ready,
	output logic signed [pcxt_pkg::SND_W-1:0] audio,
	output logic                              audio_valid,
	input  logic                              audio_ready,

	// Status
	input  logic                              activity,
	output logic                              led_user,
	output logic                              cpu_hold,
	output logic [pcxt_pkg::AR_W-1:0]         video_arx,
	output logic [pcxt_pkg::AR_W-1:0]         video_ary
);

	logic core_reset;
	logic splash_active;

	////////////////////////////////////////////////////////////////////////////
	// Reset and CPU hold
	////////////////////////////////////////////////////////////////////////////

	assign core_reset = reset || cfg.reset_req;
	// CPU stays parked through reset and splash
	assign cpu_hold   = core_reset || splash_active;

	splash_timer #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND)
	) u_splash_timer (
		.CLK_50M      (CLK_50M),
		.reset        (core_reset),
		.skip         (cfg.skip_splash),
		.splash_active(splash_active)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video and aspect
	////////////////////////////////////////////////////////////////////////////

	mono_tint u_mono_tint (
		.CLK_50M   (CLK_50M),
		.reset     (core_reset),
		.video_mode(cfg.video_mode),
		.tint      (cfg.cga_tint),
		.pix_in    (pix_in),
		.pix_out   (pix_out)
	);

	// Aspect 0 is native 4:3 and other values pick scaler presets
	always_comb begin
		if (cfg.aspect == 2'd0) begin
			video_arx = pcxt_pkg::AR_W'(4);
			video_ary = pcxt_pkg::AR_W'(3);
		end else begin
			video_arx = pcxt_pkg::AR_W'(cfg.aspect) - 1'b1;
			video_ary = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Audio and LED
	////////////////////////////////////////////////////////////////////////////

	sound_mixer u_sound_mixer (
		.CLK_50M     (CLK_50M),
		.reset       (core_reset),
		.snd_in      (snd_in),
		.snd_in_valid(snd_in_valid),
		.snd_in_ready(snd_in_ready),
		.audio       (audio),
		.audio_valid (audio_valid),
		.audio_ready (audio_ready)
	);

	activity_led #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) u_activity_led (
		.CLK_50M (CLK_50M),
		.reset   (core_reset),
		.activity(activity),
		.led_user(led_user)
	);

endmodule

// ==== rtl/pcxt_pkg.sv ====
// Shared widths, timing defaults, luma tables and grouped types for the
// PC/XT front end. Counter widths are sized from the package defaults, so
// TICKS_PER_SECOND and HOLD_CYCLES overrides must fit those widths.

package pcxt_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and timing
	////////////////////////////////////////////////////////////////////////////

	// Core colour channel and board channel
	localparam int COLOR_W = 6;
	localparam int VGA_W   = 8;
	localparam int PAD_W   = VGA_W - COLOR_W;

	// Splash hold and LED stretch defaults at 50 MHz
	localparam int unsigned SPLASH_SECONDS  = 5;
	localparam int unsigned CLK_HZ          = 50_000_000;
	localparam int unsigned LED_HOLD_CYCLES = 4_500_000;

	// Counter widths
	localparam int TICK_W = $clog2(CLK_HZ);
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);
	localparam int LED_W  = $clog2(LED_HOLD_CYCLES + 1);

	// Audio
	localparam int SND_W   = 16;
	localparam int TANDY_W = 8;
	localparam int MIX_W   = 17;

	// HDMI aspect fields, bit 12 unused here
	localparam int AR_W = 13;

	typedef logic [TICK_W-1:0] tick_cnt_t;
	typedef logic [SEC_W-1:0]  sec_cnt_t;
	typedef logic [LED_W-1:0]  led_cnt_t;

	////////////////////////////////////////////////////////////////////////////
	// Luma weights, Rec.709 coefficients scaled by 1e4
	////////////////////////////////////////////////////////////////////////////

	localparam int unsigned LUMA_SCALE  = 10_000;
	localparam int unsigned LUMA_R_COEF = 2126;
	localparam int unsigned LUMA_G_COEF = 7152;
	localparam int unsigned LUMA_B_COEF = 722;

	typedef logic [2**COLOR_W-1:0][COLOR_W-1:0] weight_tab_t;

	// Truncating product, so full white sums to 13 + 45 + 4 = 62
	function automatic weight_tab_t make_weights(int unsigned coef);
		weight_tab_t tab;
		for (int unsigned i = 0; i < 2**COLOR_W; i++) begin
			tab[i] = COLOR_W'((i * coef) / LUMA_SCALE);
		end
		return tab;
	endfunction

	localparam weight_tab_t RED_WEIGHT   = make_weights(LUMA_R_COEF);
	localparam weight_tab_t GREEN_WEIGHT = make_weights(LUMA_G_COEF);
	localparam weight_tab_t BLUE_WEIGHT  = make_weights(LUMA_B_COEF);

	////////////////////////////////////////////////////////////////////////////
	// Option encodings and grouped signals
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		TINT_COLOR,
		TINT_GREEN,
		TINT_AMBER,
		TINT_BW
	} tint_t;

	typedef enum logic {
		VIDEO_CGA,
		VIDEO_MDA
	} video_mode_t;

	// OSD option word, seven bits
	typedef struct packed {
		logic        reset_req;
		logic        skip_splash;
		video_mode_t video_mode;
		tint_t       cga_tint;
		logic [1:0]  aspect;
	} osd_cfg_t;

	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
		logic               hs;
		logic               vs;
		logic               de;
	} pixel_t;

	typedef struct packed {
		logic [VGA_W-1:0] r;
		logic [VGA_W-1:0] g;
		logic [VGA_W-1:0] b;
		logic             hs;
		logic             vs;
		logic             de;
	} vga_t;

	// Raw sources, OPL signed, Tandy unsigned
	typedef struct packed {
		logic signed [SND_W-1:0] opl;
		logic [TANDY_W-1:0]      tandy;
		logic                    speaker;
	} snd_in_t;

endpackage

// ==== rtl/sound_mixer.sv ====
// Signed mix of OPL, Tandy and PC speaker into one 16-bit sample.
// Valid/ready on both sides, one-entry output register, no sample dropped.
// The 17-bit sum wraps, as the original mixer did.

`timescale 1ns/1ps

module sound_mixer (
	input  logic                           CLK_50M,
	input  logic                           reset,
	input  pcxt_pkg::snd_in_t              snd_in,
	input  logic                           snd_in_valid,
	output logic                           snd_in_ready,
	output logic signed [pcxt_pkg::SND_W-1:0] audio,
	output logic                           audio_valid,
	input  logic                           audio_ready
);

	logic [pcxt_pkg::MIX_W-1:0] opl_part;
	logic [pcxt_pkg::MIX_W-1:0] spk_part;
	logic [pcxt_pkg::MIX_W-1:0] tandy_part;
	logic [pcxt_pkg::MIX_W-1:0] mix_sum;
	logic                       in_fire;

	////////////////////////////////////////////////////////////////////////////
	// Mix terms
	////////////////////////////////////////////////////////////////////////////

	// OPL sign-extended then x4
	assign opl_part   = {snd_in.opl[pcxt_pkg::SND_W-1], snd_in.opl} << 2;
	// Speaker bit at 32768
	assign spk_part   = {1'b0, snd_in.speaker, {(pcxt_pkg::SND_W-1){1'b0}}};
	// Tandy x64
	assign tandy_part = {{(pcxt_pkg::MIX_W-pcxt_pkg::TANDY_W-6){1'b0}}, snd_in.tandy, 6'd0};
	assign mix_sum    = opl_part + spk_part + tandy_part;

	////////////////////////////////////////////////////////////////////////////
	// Handshake and output register
	////////////////////////////////////////////////////////////////////////////

	// Ready when empty or draining this cycle
	assign snd_in_ready = !audio_valid || audio_ready;
	assign in_fire      = snd_in_valid && snd_in_ready;

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			audio_valid <= 1'b0;
		end else if (in_fire) begin
			audio_valid <= 1'b1;
		end else if (audio_ready) begin
			audio_valid <= 1'b0;
		end
	end

	// Sample payload, halved
	always_ff @(posedge CLK_50M) begin
		if (in_fire) begin
			audio <= signed'(mix_sum[pcxt_pkg::MIX_W-1:1]);
		end
	end

	a_hold_stable: assert property (@(posedge CLK_50M) disable iff (reset)
		audio_valid && !audio_ready |=> audio_valid && $stable(audio))
	else $error("audio changed under back-pressure");

endmodule

// ==== rtl/splash_timer.sv ====
// Holds the CPU for SPLASH_SECONDS after reset, or until skip is seen.
// TICKS_PER_SECOND must fit the package tick counter width.

`timescale 1ns/1ps

module splash_timer #(
	parameter int unsigned TICKS_PER_SECOND = pcxt_pkg::CLK_HZ
) (
	input  logic CLK_50M,
	input  logic reset,
	input  logic skip,
	output logic splash_active
);

	pcxt_pkg::tick_cnt_t tick_cnt;
	pcxt_pkg::sec_cnt_t  sec_cnt;

	// Counters only run while the splash is up
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (skip) begin
				// Skip ends the hold on the next edge
				splash_active <= 1'b0;
			end else if (tick_cnt == pcxt_pkg::tick_cnt_t'(TICKS_PER_SECOND - 1)) begin
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
				// Last second done
				if (sec_cnt == pcxt_pkg::sec_cnt_t'(pcxt_pkg::SPLASH_SECONDS - 1)) begin
					splash_active <= 1'b0;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	a_sec_bound: assert property (@(posedge CLK_50M) disable iff (reset)
		sec_cnt <= pcxt_pkg::sec_cnt_t'(pcxt_pkg::SPLASH_SECONDS))
	else $error("splash seconds counter overrun");

endmodule
